// File: compile.f
+incdir+common
+incdir+tests
common/fp_types_pkg.sv
common/fp_alu_pkg.sv
design/fp_normalise.sv
fp_add/fp_add_core.sv
fp_mul/fp_mul_core.sv
design/fp_special.sv
design/fp_alu_ctrl.sv
design/fp_alu_top.sv
tests/tb_fp_alu.sv

// File: Makefile
TOP := tb_fp_alu

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --timescale 1ns/1ps -f compile.f --top-module $(TOP) -o sim_$(TOP)

run: compile
	./obj_dir/sim_$(TOP) | tee sim.log
	@if grep -q "Simulation failed" sim.log; then exit 1; fi
	@grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tests/tb_fp_vectors.svh
`ifndef TB_FP_VECTORS_SVH
`define TB_FP_VECTORS_SVH

// one row per transaction: opcode, operand a, operand b, expected result word
typedef struct packed {
    fp_alu_pkg::fp_op_e op;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [31:0]        res;
} vec_t;

vec_t  vectors [$];
string vec_names [$];

function automatic void add_vector(input string name, input fp_alu_pkg::fp_op_e op,
                                   input logic [31:0] a, input logic [31:0] b,
                                   input logic [31:0] res);
    vec_t v;
    v.op  = op;
    v.a   = a;
    v.b   = b;
    v.res = res;
    vectors.push_back(v);
    vec_names.push_back(name);
endfunction

function automatic void load_vectors();
    add_vector("add 1.5+2.25", OP_ADD, 32'h3FC0_0000, 32'h4010_0000, 32'h4070_0000);
    add_vector("add carry 1.5+1.5", OP_ADD, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4040_0000);
    add_vector("add 5.0+(-2.0)", OP_ADD, 32'h40A0_0000, 32'hC000_0000, 32'h4040_0000);
    add_vector("add -1.0+0.25", OP_ADD, 32'hBF80_0000, 32'h3E80_0000, 32'hBF40_0000);
    add_vector("sub 3.75-1.5", OP_SUB, 32'h4070_0000, 32'h3FC0_0000, 32'h4010_0000);
    add_vector("sub 1.0-0.9375", OP_SUB, 32'h3F80_0000, 32'h3F70_0000, 32'h3D80_0000);
    add_vector("sub 2.5-2.5", OP_SUB, 32'h4020_0000, 32'h4020_0000, 32'h0000_0000);
    add_vector("sub -2.5-(-2.5)", OP_SUB, 32'hC020_0000, 32'hC020_0000, 32'h0000_0000);
    add_vector("mul 1.5*2.5", OP_MUL, 32'h3FC0_0000, 32'h4020_0000, 32'h4070_0000);
    add_vector("mul -2.0*3.0", OP_MUL, 32'hC000_0000, 32'h4040_0000, 32'hC0C0_0000);
    add_vector("mul carry 1.5*1.5", OP_MUL, 32'h3FC0_0000, 32'h3FC0_0000, 32'h4010_0000);
    add_vector("mul overflow", OP_MUL, 32'h7180_0000, 32'h7180_0000, 32'h7F80_0000);
    add_vector("nan a quieted", OP_ADD, 32'h7FA0_0000, 32'h3F80_0000, 32'h7FE0_0000);
    add_vector("nan b quieted", OP_MUL, 32'h4000_0000, 32'hFF80_0001, 32'hFFC0_0001);
    add_vector("nan a before b", OP_SUB, 32'h7F80_0010, 32'h7FC0_0000, 32'h7FC0_0010);
    add_vector("add 3.0+0", OP_ADD, 32'h4040_0000, 32'h0000_0000, 32'h4040_0000);
    add_vector("sub 0-3.0", OP_SUB, 32'h0000_0000, 32'h4040_0000, 32'hC040_0000);
    add_vector("sub inf-inf", OP_SUB, 32'h7F80_0000, 32'h7F80_0000, 32'h7FC0_0000);
    add_vector("add inf+inf", OP_ADD, 32'h7F80_0000, 32'h7F80_0000, 32'h7F80_0000);
    add_vector("add -inf+5.0", OP_ADD, 32'hFF80_0000, 32'h40A0_0000, 32'hFF80_0000);
    add_vector("mul 0*-inf", OP_MUL, 32'h0000_0000, 32'hFF80_0000, 32'h7FC0_0000);
    add_vector("mul -0*5.0", OP_MUL, 32'h8000_0000, 32'h40A0_0000, 32'h8000_0000);
    add_vector("mul inf*-2.0", OP_MUL, 32'h7F80_0000, 32'hC000_0000, 32'hFF80_0000);
    add_vector("reserved opcode", OP_RSVD, 32'h3F80_0000, 32'h4000_0000, 32'h7FC0_0000);
endfunction

`endif

// File: tests/tb_fp_alu.sv
`timescale 1ns/1ps

module tb_fp_alu;

    import fp_types_pkg::*;
    import fp_alu_pkg::*;

    `include "tb_fp_vectors.svh"

    localparam int TIMEOUT = 50;

    logic     clk;
    logic     i_rst;
    logic     i_req;
    fp_op_e   i_op;
    fp_word_t i_a;
    fp_word_t i_b;
    logic     o_ack;
    fp_word_t o_result;

    int   errors;
    int   passed;
    int   failed;
    int   seed;
    logic timed_out;

    fp_alu_top dut_i (
        .clk      (clk),
        .i_rst    (i_rst),
        .i_req    (i_req),
        .i_op     (i_op),
        .i_a      (i_a),
        .i_b      (i_b),
        .o_ack    (o_ack),
        .o_result (o_result)
    );

    always #50 clk = ~clk;

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, name, actual, expected);
            errors++;
        end
    endtask

    // counts falling edges until o_ack reaches the level
    task automatic wait_ack(input logic level, output int cycles);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (o_ack !== level && cycles < TIMEOUT);
        if (o_ack !== level) begin
            $display("timeout: o_ack did not go to %0d within %0d cycles", level, TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    // one four-phase transaction, entered and left on a falling edge
    task automatic run_vector(input int idx);
        vec_t v;
        int   cycles;
        int   hold;
        int   errs_before;
        logic ok;
        v           = vectors[idx];
        errs_before = errors;
        i_op        = v.op;
        i_a.raw     = v.a;
        i_b.raw     = v.b;
        i_req       = 1'b1;
        wait_ack(1'b1, cycles);
        if (!timed_out) begin
            // first negedge follows the edge that samples i_req
            check("o_ack rise latency", cycles - 1, 2);
            check("o_result", o_result.raw, v.res);
            hold = $random(seed) & 32'h7;
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                check("o_ack under hold", {31'b0, o_ack}, 32'd1);
                check("o_result under hold", o_result.raw, v.res);
            end
            i_req   = 1'b0;
            i_a.raw = $random(seed);
            i_b.raw = $random(seed);
            wait_ack(1'b0, cycles);
        end
        if (!timed_out) begin
            check("o_ack fall latency", cycles - 1, 1);
        end
        ok = (errors == errs_before) && !timed_out;
        if (ok) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test %0d %s: %s", idx, vec_names[idx], ok ? "ok" : "mismatch");
    endtask

    initial begin
        clk       = 1'b0;
        i_rst     = 1'b1;
        i_req     = 1'b0;
        i_op      = OP_ADD;
        i_a       = '0;
        i_b       = '0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        seed      = 32'h5516_e660;
        load_vectors();

        repeat (5) @(negedge clk);
        i_rst = 1'b0;

        // idle unit keeps ack low and result cleared
        for (int i = 0; i < 4; i++) begin
            @(negedge clk);
            check("o_ack idle", {31'b0, o_ack}, 32'd0);
            check("o_result idle", o_result.raw, 32'h0);
        end
        if (errors == 0) begin
            passed++;
        end else begin
            failed++;
        end
        $display("test reset idle: %s", (errors == 0) ? "ok" : "mismatch");

        for (int i = 0; i < vectors.size() && !timed_out; i++) begin
            run_vector(i);
        end

        $display("summary: %0d tests, %0d passed, %0d failed, %0d check errors",
                 passed + failed, passed, failed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: design/fp_alu_top.sv
`timescale 1ns/1ps

module fp_alu_top (
    input  logic                   clk,
    input  logic                   i_rst,
    input  logic                   i_req,
    input  fp_alu_pkg::fp_op_e     i_op,
    input  fp_types_pkg::fp_word_t i_a,
    input  fp_types_pkg::fp_word_t i_b,
    output logic                   o_ack,
    output fp_types_pkg::fp_word_t o_result
);

    import fp_types_pkg::*;
    import fp_alu_pkg::*;

    fp_req_t     cur;
    fp_special_t special;
    fp_word_t    add_res;
    fp_word_t    mul_res;
    logic        is_sub;

    assign is_sub = (cur.op == OP_SUB);

    fp_alu_ctrl ctrl_i (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_req     (i_req),
        .i_op      (i_op),
        .i_a       (i_a),
        .i_b       (i_b),
        .i_special (special),
        .i_add_res (add_res),
        .i_mul_res (mul_res),
        .o_cur     (cur),
        .o_ack     (o_ack),
        .o_result  (o_result)
    );

    fp_special special_i (
        .i_cur     (cur),
        .o_special (special)
    );

    fp_add_core add_i (
        .i_a   (cur.a),
        .i_b   (cur.b),
        .i_sub (is_sub),
        .o_sum (add_res)
    );

    fp_mul_core mul_i (
        .i_a    (cur.a),
        .i_b    (cur.b),
        .o_prod (mul_res)
    );

endmodule

// File: design/fp_alu_ctrl.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_alu_ctrl (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_req,
    input  fp_alu_pkg::fp_op_e      i_op,
    input  fp_types_pkg::fp_word_t  i_a,
    input  fp_types_pkg::fp_word_t  i_b,
    input  fp_alu_pkg::fp_special_t i_special,
    input  fp_types_pkg::fp_word_t  i_add_res,
    input  fp_types_pkg::fp_word_t  i_mul_res,
    output fp_alu_pkg::fp_req_t     o_cur,
    output logic                    o_ack,
    output fp_types_pkg::fp_word_t  o_result
);

    import fp_types_pkg::*;
    import fp_alu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUSY,
        ST_DONE
    } state_e;

    state_e   state;
    logic     req_q;
    fp_word_t sel;

    // the FSM works from the registered request line
    always_ff @(posedge clk) begin
        if (i_rst) begin
            req_q    <= 1'b0;
            state    <= ST_IDLE;
            o_ack    <= 1'b0;
            o_result <= '0;
        end else begin
            req_q <= i_req;
            case (state)
                ST_IDLE: begin
                    if (req_q) begin
                        state <= ST_BUSY;
                    end
                end
                ST_BUSY: begin
                    o_result <= sel;
                    o_ack    <= 1'b1;
                    state    <= ST_DONE;
                end
                ST_DONE: begin
                    // hold ack and result until the requester lets go
                    if (!req_q) begin
                        o_ack <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // operands stay stable until ack, one capture per request
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && req_q) begin
            o_cur <= '{op: i_op, a: i_a, b: i_b};
        end
    end

    always_comb begin
        if (o_cur.op == OP_RSVD) begin
            sel.raw = `FP_QNAN;
        end else if (i_special.take) begin
            sel = i_special.value;
        end else if (o_cur.op == OP_MUL) begin
            sel = i_mul_res;
        end else begin
            sel = i_add_res;
        end
    end

endmodule

// File: design/fp_special.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_special (
    input  fp_alu_pkg::fp_req_t     i_cur,
    output fp_alu_pkg::fp_special_t o_special
);

    import fp_types_pkg::*;
    import fp_alu_pkg::*;

    fp_word_t a;
    fp_word_t b;
    fp_word_t b_eff;
    fp_word_t a_quiet;
    fp_word_t b_quiet;
    logic     a_nan;
    logic     a_inf;
    logic     a_zero;
    logic     b_nan;
    logic     b_inf;
    logic     b_zero;
    logic     sign_x;

    assign a = i_cur.a;
    assign b = i_cur.b;

    assign a_nan  = (a.fields.exp == `FP_EXP_MAX) && (a.fields.frac != '0);
    assign a_inf  = (a.fields.exp == `FP_EXP_MAX) && (a.fields.frac == '0);
    assign a_zero = (a.fields.exp == '0) && (a.fields.frac == '0);
    assign b_nan  = (b.fields.exp == `FP_EXP_MAX) && (b.fields.frac != '0);
    assign b_inf  = (b.fields.exp == `FP_EXP_MAX) && (b.fields.frac == '0);
    assign b_zero = (b.fields.exp == '0) && (b.fields.frac == '0);

    assign sign_x = a.fields.sign ^ b.fields.sign;

    always_comb begin
        // subtract is add with B negated
        b_eff             = b;
        b_eff.fields.sign = b.fields.sign ^ (i_cur.op == OP_SUB);
        a_quiet           = a;
        a_quiet.fields.frac[`FP_FRAC_W-1] = 1'b1;
        b_quiet           = b;
        b_quiet.fields.frac[`FP_FRAC_W-1] = 1'b1;
    end

    always_comb begin
        o_special.take  = 1'b1;
        o_special.value = a;
        if (i_cur.op == OP_RSVD) begin
            o_special.take = 1'b0;
        end else if (a_nan) begin
            o_special.value = a_quiet;
        end else if (b_nan) begin
            o_special.value = b_quiet;
        end else if (i_cur.op == OP_MUL) begin
            if ((a_inf && b_zero) || (a_zero && b_inf)) begin
                o_special.value.raw = `FP_QNAN;
            end else if (a_inf || b_inf) begin
                o_special.value.fields = '{sign: sign_x, exp: '1, frac: '0};
            end else if (a_zero || b_zero) begin
                o_special.value.fields = '{sign: sign_x, exp: '0, frac: '0};
            end else begin
                o_special.take = 1'b0;
            end
        end else begin
            if (a_inf && b_inf) begin
                if (a.fields.sign != b_eff.fields.sign) begin
                    o_special.value.raw = `FP_QNAN;
                end
            end else if (b_inf || a_zero) begin
                o_special.value = b_eff;
            end else if (!a_inf && !b_zero) begin
                o_special.take = 1'b0;
            end
        end
    end

endmodule

// File: fp_mul/fp_mul_core.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_mul_core (
    input  fp_types_pkg::fp_word_t i_a,
    input  fp_types_pkg::fp_word_t i_b,
    output fp_types_pkg::fp_word_t o_prod
);

    import fp_types_pkg::*;

    localparam int                  PROD_W = 2 * `FP_MANT_W;
    localparam logic [`FP_EXP_W+1:0] BIAS_X = `FP_EXP_BIAS;

    fp_unpacked_t                ua;
    fp_unpacked_t                ub;
    logic                        sign;
    logic [PROD_W-1:0]           prod;
    logic [PROD_W-1:0]           norm_in;
    logic signed [`FP_EXP_W+1:0] exp_pre;
    logic [`FP_EXP_W-1:0]        n_exp;
    logic [PROD_W-1:0]           n_mant;

    assign ua   = fp_unpack(i_a);
    assign ub   = fp_unpack(i_b);
    assign sign = ua.sign ^ ub.sign;
    assign prod = ua.mant * ub.mant;

    // top-bit carry counts as a right shift, so the exponent goes up by one
    assign norm_in = prod[PROD_W-1] ? prod : {prod[PROD_W-2:0], 1'b0};

    // two extra bits keep the sum signed and free of wrap
    assign exp_pre = {2'b00, ua.exp} + {2'b00, ub.exp}
                   + {{(`FP_EXP_W+1){1'b0}}, prod[PROD_W-1]} - BIAS_X;

    fp_normalise #(
        .MANT_W (PROD_W)
    ) norm_i (
        .i_exp  (exp_pre[`FP_EXP_W-1:0]),
        .i_mant (norm_in),
        .o_exp  (n_exp),
        .o_mant (n_mant)
    );

    // normalising only lowers the exponent, so range checks can use exp_pre
    always_comb begin
        if (exp_pre >= `FP_EXP_MAX) begin
            o_prod.fields = '{sign: sign, exp: '1, frac: '0};
        end else if (exp_pre < 1) begin
            o_prod.fields = '{sign: sign, exp: '0, frac: '0};
        end else begin
            o_prod.fields = '{sign: sign,
                              exp:  n_exp,
                              frac: n_mant[PROD_W-2 -: `FP_FRAC_W]};
        end
    end

endmodule

// File: fp_add/fp_add_core.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

module fp_add_core (
    input  fp_types_pkg::fp_word_t i_a,
    input  fp_types_pkg::fp_word_t i_b,
    input  logic                   i_sub,
    output fp_types_pkg::fp_word_t o_sum
);

    import fp_types_pkg::*;

    fp_unpacked_t          ua;
    fp_unpacked_t          ub;
    fp_unpacked_t          lead;
    fp_unpacked_t          trail;
    logic [`FP_EXP_W-1:0]  diff;
    logic [`FP_MANT_W-1:0] aligned;
    logic [`FP_MANT_W:0]   sum;
    logic [`FP_EXP_W:0]    exp_inc;
    logic [`FP_EXP_W-1:0]  n_exp;
    logic [`FP_MANT_W-1:0] n_mant;

    always_comb begin
        ua      = fp_unpack(i_a);
        ub      = fp_unpack(i_b);
        ub.sign = ub.sign ^ i_sub;
    end

    // larger magnitude leads and gives the sign
    always_comb begin
        if ({ua.exp, ua.mant} >= {ub.exp, ub.mant}) begin
            lead  = ua;
            trail = ub;
        end else begin
            lead  = ub;
            trail = ua;
        end
    end

    assign diff    = lead.exp - trail.exp;
    assign aligned = trail.mant >> diff;

    assign sum = (lead.sign == trail.sign) ? {1'b0, lead.mant} + {1'b0, aligned}
                                           : {1'b0, lead.mant} - {1'b0, aligned};

    assign exp_inc = {1'b0, lead.exp} + 1'b1;

    fp_normalise #(
        .MANT_W (`FP_MANT_W)
    ) norm_i (
        .i_exp  (lead.exp),
        .i_mant (sum[`FP_MANT_W-1:0]),
        .o_exp  (n_exp),
        .o_mant (n_mant)
    );

    always_comb begin
        if (sum[`FP_MANT_W]) begin
            // carry out, shift right by one
            if (exp_inc >= `FP_EXP_MAX) begin
                o_sum.fields = '{sign: lead.sign, exp: '1, frac: '0};
            end else begin
                o_sum.fields = '{sign: lead.sign,
                                 exp:  exp_inc[`FP_EXP_W-1:0],
                                 frac: sum[`FP_MANT_W-1:1]};
            end
        end else begin
            // exact cancellation comes out as +0
            o_sum.fields = '{sign: lead.sign & (sum != '0),
                             exp:  n_exp,
                             frac: n_mant[`FP_FRAC_W-1:0]};
        end
    end

endmodule

// File: design/fp_normalise.sv
`timescale 1ns/1ps
`include "fp_cfg.svh"

// leading one moves to the top bit, the caller has already removed any carry bit
module fp_normalise #(
    parameter int MANT_W = `FP_MANT_W
) (
    input  logic [`FP_EXP_W-1:0] i_exp,
    input  logic [MANT_W-1:0]    i_mant,
    output logic [`FP_EXP_W-1:0] o_exp,
    output logic [MANT_W-1:0]    o_mant
);

    localparam int EW = `FP_EXP_W;

    logic          found;
    logic [EW-1:0] shift;

    always_comb begin
        found = 1'b0;
        shift = '0;
        for (int i = MANT_W - 1; i >= 0; i--) begin
            if (!found && i_mant[i]) begin
                found = 1'b1;
                shift = EW'(MANT_W - 1 - i);
            end
        end
    end

    // exponent would reach 0 or below, flush to zero
    always_comb begin
        if (!found || shift >= i_exp) begin
            o_exp  = '0;
            o_mant = '0;
        end else begin
            o_exp  = i_exp - shift;
            o_mant = i_mant << shift;
        end
    end

endmodule

// File: common/fp_alu_pkg.sv
package fp_alu_pkg;

    // code 2'b10 used to be divide
    typedef enum logic [1:0] {
        OP_ADD  = 2'b00,
        OP_SUB  = 2'b01,
        OP_RSVD = 2'b10,
        OP_MUL  = 2'b11
    } fp_op_e;

    typedef struct packed {
        fp_op_e                 op;
        fp_types_pkg::fp_word_t a;
        fp_types_pkg::fp_word_t b;
    } fp_req_t;

    // take set means value replaces the core results
    typedef struct packed {
        logic                   take;
        fp_types_pkg::fp_word_t value;
    } fp_special_t;

endpackage

// File: common/fp_types_pkg.sv
`include "fp_cfg.svh"

package fp_types_pkg;

    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_FRAC_W-1:0] frac;
    } fp_fields_t;

    // one word, seen as raw bits or as fields
    typedef union packed {
        logic [`FP_EXP_W+`FP_FRAC_W:0] raw;
        fp_fields_t                    fields;
    } fp_word_t;

    // operand with effective exponent and explicit hidden bit
    typedef struct packed {
        logic                  sign;
        logic [`FP_EXP_W-1:0]  exp;
        logic [`FP_MANT_W-1:0] mant;
    } fp_unpacked_t;

    // subnormal reads as exponent 1 without the hidden bit
    function automatic fp_unpacked_t fp_unpack(input fp_word_t w);
        fp_unpacked_t u;
        u.sign = w.fields.sign;
        if (w.fields.exp == '0) begin
            u.exp  = {{(`FP_EXP_W-1){1'b0}}, 1'b1};
            u.mant = {1'b0, w.fields.frac};
        end else begin
            u.exp  = w.fields.exp;
            u.mant = {1'b1, w.fields.frac};
        end
        return u;
    endfunction

endpackage

// File: common/fp_cfg.svh
`ifndef FP_CFG_SVH
`define FP_CFG_SVH

// single precision word layout
`define FP_EXP_W    8
`define FP_FRAC_W   23
// fraction plus hidden bit
`define FP_MANT_W   24

`define FP_EXP_BIAS 127

// all-ones exponent marks infinity and NaN
`define FP_EXP_MAX  255

// canonical quiet NaN for invalid operations
`define FP_QNAN     32'h7FC0_0000

`endif
